/* src.f */
hdl/mesh_route_pkg.sv
hdl/route_req_capture.sv
hdl/turn_model_select.sv
hdl/odd_even_select.sv
hdl/route_port_select.sv
hdl/dest_port_encoder.sv
hdl/mesh_route_top.sv
dv/mesh_route_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := mesh_route_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/mesh_route_tb.sv */
module mesh_route_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mesh_route_pkg::*;

    typedef struct packed {
        route_algo_e algo;
        logic [1:0]  cur_x;
        logic [1:0]  cur_y;
        logic [1:0]  dst_x;
        logic [1:0]  dst_y;
        port_mask_t  mask;
        dest_code_t  code;
    } route_vec_t;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    route_algo_e algo;
    logic [1:0]  cur_x;
    logic [1:0]  cur_y;
    logic [1:0]  dst_x;
    logic [1:0]  dst_y;
    logic        route_valid;
    port_mask_t  route_mask;
    dest_code_t  route_code;

    route_vec_t  vecs[$];
    int          pend_num[$];  // test number of each request in flight
    int          pend_edge[$]; // clock edge where its result is due
    int          cyc = 0;
    int          errors = 0;
    int          done = 0;
    logic [15:0] lfsr = 16'd37326;

    mesh_route_top #(
        .NX       (4),
        .NY       (4),
        .OE_AT_NI (0)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .algo        (algo),
        .cur_x       (cur_x),
        .cur_y       (cur_y),
        .dst_x       (dst_x),
        .dst_y       (dst_y),
        .route_valid (route_valid),
        .route_mask  (route_mask),
        .route_code  (route_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1; // edge count for the monitor

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic take_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    task automatic add_vec(
        input route_algo_e a,
        input logic [1:0]  cx,
        input logic [1:0]  cy,
        input logic [1:0]  dx,
        input logic [1:0]  dy,
        input port_mask_t  m,
        input dest_code_t  c
    );
        vecs.push_back('{a, cx, cy, dx, dy, m, c});
    endtask

    // mask bits S W N E L
    // code bits east north horiz vert
    task automatic fill_table();
        add_vec(algo_xy,         2'd1, 2'd1, 2'd1, 2'd1, 5'b00001, 4'b0000); // local
        add_vec(algo_west_first, 2'd2, 2'd2, 2'd2, 2'd2, 5'b00001, 4'b0000);
        add_vec(algo_north_last, 2'd0, 2'd3, 2'd0, 2'd3, 5'b00001, 4'b0000);
        add_vec(algo_neg_first,  2'd3, 2'd0, 2'd3, 2'd0, 5'b00001, 4'b0000);
        add_vec(algo_odd_even,   2'd1, 2'd2, 2'd1, 2'd2, 5'b00001, 4'b0000);
        add_vec(algo_duato,      2'd2, 2'd1, 2'd2, 2'd1, 5'b00001, 4'b0000);
        add_vec(algo_xy,         2'd1, 2'd1, 2'd3, 2'd1, 5'b00010, 4'b1010); // east
        add_vec(algo_west_first, 2'd2, 2'd1, 2'd0, 2'd1, 5'b01000, 4'b0010); // west
        add_vec(algo_north_last, 2'd1, 2'd2, 2'd1, 2'd0, 5'b00100, 4'b0101); // north
        add_vec(algo_neg_first,  2'd1, 2'd1, 2'd1, 2'd3, 5'b10000, 4'b0001); // south
        add_vec(algo_odd_even,   2'd2, 2'd2, 2'd2, 2'd0, 5'b00100, 4'b0101);
        add_vec(algo_duato,      2'd3, 2'd2, 2'd1, 2'd2, 5'b01000, 4'b0010);
        add_vec(algo_xy,         2'd2, 2'd2, 2'd0, 2'd0, 5'b01000, 4'b0110); // wn
        add_vec(algo_xy,         2'd2, 2'd1, 2'd0, 2'd3, 5'b01000, 4'b0010); // ws
        add_vec(algo_xy,         2'd0, 2'd2, 2'd2, 2'd0, 5'b00010, 4'b1110); // en
        add_vec(algo_xy,         2'd1, 2'd1, 2'd3, 2'd3, 5'b00010, 4'b1010); // es
        add_vec(algo_west_first, 2'd3, 2'd2, 2'd1, 2'd0, 5'b01000, 4'b0110); // wn
        add_vec(algo_west_first, 2'd2, 2'd2, 2'd0, 2'd3, 5'b01000, 4'b0010); // ws
        add_vec(algo_west_first, 2'd1, 2'd2, 2'd3, 2'd0, 5'b00110, 4'b1111); // en
        add_vec(algo_west_first, 2'd0, 2'd0, 2'd2, 2'd2, 5'b10010, 4'b1011); // es
        add_vec(algo_north_last, 2'd3, 2'd1, 2'd1, 2'd3, 5'b11000, 4'b0011); // ws
        add_vec(algo_north_last, 2'd1, 2'd3, 2'd3, 2'd1, 5'b00010, 4'b1110); // en
        add_vec(algo_north_last, 2'd3, 2'd3, 2'd0, 2'd0, 5'b01000, 4'b0110); // wn
        add_vec(algo_north_last, 2'd0, 2'd1, 2'd2, 2'd3, 5'b10010, 4'b1011); // es
        add_vec(algo_neg_first,  2'd2, 2'd2, 2'd0, 2'd0, 5'b01000, 4'b0110); // wn
        add_vec(algo_neg_first,  2'd2, 2'd1, 2'd0, 2'd3, 5'b11000, 4'b0011); // ws
        add_vec(algo_neg_first,  2'd0, 2'd3, 2'd2, 2'd1, 5'b00110, 4'b1111); // en
        add_vec(algo_neg_first,  2'd0, 2'd0, 2'd3, 2'd3, 5'b10000, 4'b1001); // es
        add_vec(algo_duato,      2'd3, 2'd3, 2'd1, 2'd1, 5'b01100, 4'b0111); // wn
        add_vec(algo_duato,      2'd3, 2'd0, 2'd0, 2'd2, 5'b11000, 4'b0011); // ws
        add_vec(algo_duato,      2'd0, 2'd3, 2'd3, 2'd0, 5'b00110, 4'b1111); // en
        add_vec(algo_duato,      2'd1, 2'd0, 2'd3, 2'd2, 5'b10010, 4'b1011); // es
        add_vec(algo_odd_even,   2'd0, 2'd0, 2'd3, 2'd2, 5'b00010, 4'b1010); // even col
        add_vec(algo_odd_even,   2'd1, 2'd3, 2'd3, 2'd0, 5'b00110, 4'b1111); // odd col
        add_vec(algo_odd_even,   2'd1, 2'd0, 2'd2, 2'd2, 5'b10000, 4'b1001); // adjacent even
        add_vec(algo_odd_even,   2'd2, 2'd0, 2'd0, 2'd3, 5'b11000, 4'b0011); // west from even col
        add_vec(algo_odd_even,   2'd3, 2'd3, 2'd1, 2'd1, 5'b01000, 4'b0110); // west from odd col
    endtask

    task automatic check_mask(input string ctx, input port_mask_t got, input port_mask_t exp);
        if (got !== exp) begin
            $display("** Error: route_mask got 0x%h expected 0x%h, %s", got, exp, ctx);
            errors++;
        end
    endtask

    task automatic check_code(input string ctx, input dest_code_t got, input dest_code_t exp);
        if (got !== exp) begin
            $display("** Error: route_code got 0x%h expected 0x%h, %s", got, exp, ctx);
            errors++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : monitor
        int         num;
        int         due;
        int         err_before;
        route_vec_t v;
        if (rst_n) begin
            if (route_valid) begin
                if (pend_num.size() == 0) begin
                    $display("route_valid pulsed at edge %0d with no request in flight", cyc);
                    errors++;
                end else begin
                    num = pend_num.pop_front();
                    due = pend_edge.pop_front();
                    v = vecs[num % vecs.size()];
                    err_before = errors;
                    if (cyc != due) begin
                        $display("test %0d result came at edge %0d, due at edge %0d",
                                 num, cyc, due);
                        errors++;
                    end
                    check_mask($sformatf("test %0d", num), route_mask, v.mask);
                    check_code($sformatf("test %0d", num), route_code, v.code);
                    $display("test %0d %s (%0d,%0d)->(%0d,%0d) mask 0x%h code 0x%h %s",
                             num, v.algo.name(), v.cur_x, v.cur_y, v.dst_x, v.dst_y,
                             route_mask, route_code, (errors == err_before) ? "ok" : "bad");
                    done++;
                end
            end else if (pend_edge.size() != 0 && cyc >= pend_edge[0]) begin
                $display("test %0d gave no result at edge %0d", pend_num[0], pend_edge[0]);
                errors++;
                void'(pend_num.pop_front());
                void'(pend_edge.pop_front());
                done++;
            end else if (done == 0) begin
                check_mask("idle after reset", route_mask, '0);
                check_code("idle after reset", route_code, '0);
            end
        end
    end

    initial begin : driver
        int         num;
        int         gap;
        int         wait_cnt;
        logic       b0;
        logic       b1;
        route_vec_t v;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        algo      = algo_xy;
        cur_x     = '0;
        cur_y     = '0;
        dst_x     = '0;
        dst_y     = '0;
        fill_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk); // idle outputs after reset
        num = 0;
        // random gaps on the first pass and back to back on the second
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < vecs.size(); i++) begin
                @(posedge clk);
                v = vecs[i];
                req_valid <= 1'b1;
                algo      <= v.algo;
                cur_x     <= v.cur_x;
                cur_y     <= v.cur_y;
                dst_x     <= v.dst_x;
                dst_y     <= v.dst_y;
                pend_num.push_back(num);
                pend_edge.push_back(cyc + 4); // cyc still holds the previous edge
                num++;
                gap = 0;
                if (pass == 0) begin
                    b0 = take_bit();
                    b1 = take_bit();
                    gap = int'({b1, b0}) % 3;
                end
                repeat (gap) begin
                    @(posedge clk);
                    req_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
        wait_cnt = 0;
        while (pend_num.size() != 0 && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (pend_num.size() != 0) begin
            $display("timed out with %0d results still missing", pend_num.size());
            errors++;
        end
        repeat (4) @(posedge clk); // no stray results
        $display("%0d tests sent, %0d finished, %0d errors", num, done, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* hdl/mesh_route_top.sv */
module mesh_route_top #(
    parameter int NX       = 4,
    parameter int NY       = 4,
    parameter int OE_AT_NI = 0,
    localparam int XW = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW = (NY > 1) ? $clog2(NY) : 1
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  mesh_route_pkg::route_algo_e algo,
    input  logic [XW-1:0]               cur_x,
    input  logic [YW-1:0]               cur_y,
    input  logic [XW-1:0]               dst_x,
    input  logic [YW-1:0]               dst_y,
    output logic                        route_valid,
    output mesh_route_pkg::port_mask_t  route_mask,
    output mesh_route_pkg::dest_code_t  route_code
);
    import mesh_route_pkg::*;

    // stage 1 to stage 2
    logic        s1_valid;
    route_algo_e s1_algo;
    logic        x_plus;
    logic        x_min;
    logic        y_plus;
    logic        y_min;
    logic        cur_col_odd;
    logic        dst_col_odd;
    logic        x_adjacent;

    // stage 2 to stage 3
    logic        s2_valid;
    port_mask_t  s2_mask;
    logic        east_bound;
    logic        north_bound;

    route_req_capture #(
        .NX (NX),
        .NY (NY)
    ) u_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .algo        (algo),
        .cur_x       (cur_x),
        .cur_y       (cur_y),
        .dst_x       (dst_x),
        .dst_y       (dst_y),
        .s1_valid    (s1_valid),
        .s1_algo     (s1_algo),
        .x_plus      (x_plus),
        .x_min       (x_min),
        .y_plus      (y_plus),
        .y_min       (y_min),
        .cur_col_odd (cur_col_odd),
        .dst_col_odd (dst_col_odd),
        .x_adjacent  (x_adjacent)
    );

    route_port_select #(
        .OE_AT_NI (OE_AT_NI)
    ) u_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .s1_valid    (s1_valid),
        .s1_algo     (s1_algo),
        .x_plus      (x_plus),
        .x_min       (x_min),
        .y_plus      (y_plus),
        .y_min       (y_min),
        .cur_col_odd (cur_col_odd),
        .dst_col_odd (dst_col_odd),
        .x_adjacent  (x_adjacent),
        .s2_valid    (s2_valid),
        .s2_mask     (s2_mask),
        .east_bound  (east_bound),
        .north_bound (north_bound)
    );

    dest_port_encoder u_encoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .s2_valid    (s2_valid),
        .s2_mask     (s2_mask),
        .east_bound  (east_bound),
        .north_bound (north_bound),
        .route_valid (route_valid),
        .route_mask  (route_mask),
        .route_code  (route_code)
    );

endmodule

/* hdl/dest_port_encoder.sv */
module dest_port_encoder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       s2_valid,
    input  mesh_route_pkg::port_mask_t s2_mask,
    input  logic                       east_bound,
    input  logic                       north_bound,
    output logic                       route_valid,
    output mesh_route_pkg::port_mask_t route_mask,
    output mesh_route_pkg::dest_code_t route_code
);
    import mesh_route_pkg::*;

    logic       horiz_ok;
    logic       vert_ok;
    dest_code_t code;

    assign horiz_ok = s2_mask[port_idx_east] | s2_mask[port_idx_west];
    assign vert_ok  = s2_mask[port_idx_north] | s2_mask[port_idx_south];
    assign code     = {east_bound, north_bound, horiz_ok, vert_ok};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            route_valid <= 1'b0;
            route_mask  <= '0;
            route_code  <= '0;
        end else begin
            route_valid <= s2_valid; // single-cycle strobe
            if (s2_valid) begin
                route_mask <= s2_mask;
                route_code <= code;
            end
        end
    end

endmodule

/* hdl/route_port_select.sv */
module route_port_select #(
    parameter int OE_AT_NI = 0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        s1_valid,
    input  mesh_route_pkg::route_algo_e s1_algo,
    input  logic                        x_plus,
    input  logic                        x_min,
    input  logic                        y_plus,
    input  logic                        y_min,
    input  logic                        cur_col_odd,
    input  logic                        dst_col_odd,
    input  logic                        x_adjacent,
    output logic                        s2_valid,
    output mesh_route_pkg::port_mask_t  s2_mask,
    output logic                        east_bound,
    output logic                        north_bound
);
    import mesh_route_pkg::*;

    port_mask_t turn_mask;
    port_mask_t oe_mask;

    turn_model_select u_turn (
        .algo   (s1_algo),
        .x_plus (x_plus),
        .x_min  (x_min),
        .y_plus (y_plus),
        .y_min  (y_min),
        .mask   (turn_mask)
    );

    odd_even_select #(
        .OE_AT_NI (OE_AT_NI)
    ) u_odd_even (
        .x_plus      (x_plus),
        .x_min       (x_min),
        .y_plus      (y_plus),
        .y_min       (y_min),
        .cur_col_odd (cur_col_odd),
        .dst_col_odd (dst_col_odd),
        .x_adjacent  (x_adjacent),
        .mask        (oe_mask)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_mask     <= (s1_algo == algo_odd_even) ? oe_mask : turn_mask;
            east_bound  <= x_plus;
            north_bound <= y_min;
        end
    end

endmodule

/* hdl/odd_even_select.sv */
module odd_even_select #(
    parameter int OE_AT_NI = 0 // 1 when the unit sits in the network interface
) (
    input  logic                       x_plus,
    input  logic                       x_min,
    input  logic                       y_plus,
    input  logic                       y_min,
    input  logic                       cur_col_odd,
    input  logic                       dst_col_odd,
    input  logic                       x_adjacent,
    output mesh_route_pkg::port_mask_t mask
);
    import mesh_route_pkg::*;

    logic       same_x;
    logic       same_y;
    port_mask_t v_port;

    assign same_x = !x_plus && !x_min;
    assign same_y = !y_plus && !y_min;

    always_comb begin
        v_port = '0;
        v_port[y_min ? port_idx_north : port_idx_south] = 1'b1;
    end

    always_comb begin
        mask = '0;
        if (same_x && same_y) begin
            mask[port_idx_local] = 1'b1;
        end else if (same_y) begin
            mask[x_plus ? port_idx_east : port_idx_west] = 1'b1;
        end else if (same_x) begin
            mask = v_port;
        end else if (x_plus) begin
            // east-bound, turns to vertical only in odd columns
            if (cur_col_odd || (OE_AT_NI == 1)) begin
                mask = mask | v_port;
            end
            // no east step into an even column next to the target
            if (dst_col_odd || !x_adjacent) begin
                mask[port_idx_east] = 1'b1;
            end
        end else begin
            mask[port_idx_west] = 1'b1; // west-bound
            if (!cur_col_odd) begin
                mask = mask | v_port; // even column
            end
        end
    end

endmodule

/* hdl/turn_model_select.sv */
module turn_model_select (
    input  mesh_route_pkg::route_algo_e algo,
    input  logic                        x_plus,
    input  logic                        x_min,
    input  logic                        y_plus,
    input  logic                        y_min,
    output mesh_route_pkg::port_mask_t  mask
);
    import mesh_route_pkg::*;

    logic       same_x;
    logic       same_y;
    port_mask_t h_port; // horizontal port toward the destination
    port_mask_t v_port; // vertical port toward the destination

    assign same_x = !x_plus && !x_min;
    assign same_y = !y_plus && !y_min;

    always_comb begin
        h_port = '0;
        v_port = '0;
        h_port[x_plus ? port_idx_east : port_idx_west]  = 1'b1;
        v_port[y_min ? port_idx_north : port_idx_south] = 1'b1;
    end

    always_comb begin
        mask = '0;
        if (same_x && same_y) begin
            mask[port_idx_local] = 1'b1;
        end else if (same_y) begin
            mask = h_port;
        end else if (same_x) begin
            mask = v_port;
        end else begin
            // target off both axes
            case (algo)
                algo_west_first: begin
                    // no turns into west, so west-bound goes west first
                    mask = x_plus ? (h_port | v_port) : h_port;
                end
                algo_north_last: begin
                    // north only once nothing else is left
                    mask = y_plus ? (h_port | v_port) : h_port;
                end
                algo_neg_first: begin
                    if (x_min) begin
                        mask = y_plus ? (h_port | v_port) : h_port;
                    end else if (y_min) begin
                        mask = h_port | v_port;
                    end else begin
                        mask[port_idx_south] = 1'b1; // east then south turn banned
                    end
                end
                algo_duato: begin
                    mask = h_port | v_port; // both productive ports
                end
                default: begin
                    mask = h_port; // xy, x dimension first
                end
            endcase
        end
    end

endmodule

/* hdl/route_req_capture.sv */
module route_req_capture #(
    parameter int NX = 4,
    parameter int NY = 4,
    localparam int XW = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW = (NY > 1) ? $clog2(NY) : 1
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  mesh_route_pkg::route_algo_e algo,
    input  logic [XW-1:0]               cur_x,
    input  logic [YW-1:0]               cur_y,
    input  logic [XW-1:0]               dst_x,
    input  logic [YW-1:0]               dst_y,
    output logic                        s1_valid,
    output mesh_route_pkg::route_algo_e s1_algo,
    output logic                        x_plus,
    output logic                        x_min,
    output logic                        y_plus,
    output logic                        y_min,
    output logic                        cur_col_odd,
    output logic                        dst_col_odd,
    output logic                        x_adjacent
);
    import mesh_route_pkg::*;

    logic [XW:0] x_diff; // one extra bit so the distance never wraps

    assign x_diff = {1'b0, dst_x} - {1'b0, cur_x};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_algo  <= algo_xy;
        end else begin
            s1_valid <= req_valid;
            if (req_valid) begin
                s1_algo <= algo;
            end
        end
    end

    // direction flags, only loaded with a request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            x_plus      <= (dst_x > cur_x);  // east
            x_min       <= (dst_x < cur_x);  // west
            y_plus      <= (dst_y > cur_y);  // south
            y_min       <= (dst_y < cur_y);  // north, smaller y
            cur_col_odd <= cur_x[0];
            dst_col_odd <= dst_x[0];
            x_adjacent  <= (x_diff == (XW+1)'(1)); // exactly one column east
        end
    end

endmodule

/* hdl/mesh_route_pkg.sv */
package mesh_route_pkg;

    // bit positions inside the one-hot port mask
    localparam int port_idx_local = 0;
    localparam int port_idx_east  = 1;
    localparam int port_idx_north = 2;
    localparam int port_idx_west  = 3;
    localparam int port_idx_south = 4;

    // a mesh router always has five ports
    localparam int num_ports = 5;

    // one bit per allowed output port
    typedef logic [num_ports-1:0] port_mask_t;

    // encoded destination port, msb first:
    //   [3] east-bound, [2] north-bound,
    //   [1] horizontal port allowed, [0] vertical port allowed
    typedef logic [3:0] dest_code_t;

    // routing algorithm, chosen per request
    typedef enum logic [2:0] {
        algo_xy         = 3'd0, // deterministic
        algo_west_first = 3'd1,
        algo_north_last = 3'd2,
        algo_neg_first  = 3'd3,
        algo_odd_even   = 3'd4,
        algo_duato      = 3'd5  // fully adaptive
    } route_algo_e;

endpackage
